/* logic/fe_cfg.svh */
// front end sizes, 16-byte fetch blocks
// tag width follows from the address, index and block widths
// return stack depth must be a power of two
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

`define FE_IP_W        32
`define FE_BLK_SHIFT   4
`define FE_TB_IDX_W    6      // 64 sets, address bits 9:4
`define FE_TB_TAG_W    (`FE_IP_W - `FE_TB_IDX_W - `FE_BLK_SHIFT)

`define FE_HIST_W      16
`define FE_PRED_IDX_W  10     // entries per direction table

`define FE_RAS_DEPTH   8

// first fetch address out of reset
`define FE_RESET_IP    32'h0000_1000

`endif

/* logic/fe_addr_pkg.sv */
// address, index and history types for the fetch front end
// widths come from fe_cfg.svh
`include "fe_cfg.svh"

package fe_addr_pkg;

  // fetch address, block aligned inside the sequencer
  typedef logic [`FE_IP_W-1:0] ip_t;

  // target buffer set index and tag
  typedef logic [`FE_TB_IDX_W-1:0] tb_idx_t;
  typedef logic [`FE_TB_TAG_W-1:0] tb_tag_t;

  // global history, newest outcome in bit 0
  typedef logic [`FE_HIST_W-1:0] hist_t;

  typedef logic [`FE_PRED_IDX_W-1:0] pred_idx_t;

endpackage

/* logic/fe_branch_pkg.sv */
// branch kinds and target buffer entry layout
// two slots per buffer set, slot 0 has priority
package fe_branch_pkg;

  import fe_addr_pkg::*;

  typedef enum logic [1:0] {
    br_cond   = 2'd0,
    br_uncond = 2'd1,
    br_call   = 2'd2,
    br_ret    = 2'd3
  } br_kind_e;

  typedef logic slot_t;

  // 57 bits per entry
  typedef struct packed {
    logic     valid;
    tb_tag_t  tag;
    ip_t      target;    // unused for br_ret
    br_kind_e kind;
  } tb_entry_t;

endpackage

/* logic/fe_if.sv */
// lookup and retire-update bundles between the sequencer and the tables
// lookup results are combinational from the registered fetch address
interface fe_lookup_if
  import fe_addr_pkg::*, fe_branch_pkg::*;
();
  ip_t        ip;
  hist_t      hist;
  logic [1:0] hit;
  br_kind_e   kind [2];
  ip_t        target [2];
  logic [1:0] taken_pred;   // one bit per slot

  modport seq (output ip, hist, input hit, kind, target, taken_pred);
  modport tbuf (input ip, output hit, kind, target);
  modport pred (input ip, hist, output taken_pred);
endinterface

interface fe_update_if
  import fe_addr_pkg::*, fe_branch_pkg::*;
();
  logic     wr;        // retire with mispredict
  slot_t    slot;
  br_kind_e kind;
  ip_t      src_ip;
  ip_t      target;
  hist_t    ghist;     // history seen by the branch at fetch

  modport seq (output wr, slot, kind, src_ip, target, ghist);
  modport tbuf (input wr, slot, kind, src_ip, target);
  modport pred (input wr, slot, kind, src_ip, ghist);
endinterface

/* logic/fe_fetch_seq.sv */
// fetch address and global history, next-address choice
// a retire mispredict redirects fetch and wins over prediction and stall
// the return stack is not repaired on a mispredict
`include "fe_cfg.svh"

module fe_fetch_seq
  import fe_addr_pkg::*, fe_branch_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         fetch_stall,
  input  logic         retire_valid,
  input  logic         retire_mispredict,
  input  slot_t        retire_slot,
  input  br_kind_e     retire_kind,
  input  logic         retire_taken,
  input  ip_t          retire_src_ip,
  input  ip_t          retire_target,
  input  hist_t        retire_ghist,
  fe_lookup_if.seq     lookup,
  fe_update_if.seq     update,
  input  ip_t          ras_top,
  output logic         ras_push,
  output logic         ras_pop,
  output ip_t          ras_push_addr,
  output ip_t          fetch_ip,
  output logic         fetch_valid
);

  localparam ip_t BLK_BYTES = ip_t'(1 << `FE_BLK_SHIFT);

  function automatic ip_t blk_align(input ip_t ip);
    return {ip[`FE_IP_W-1:`FE_BLK_SHIFT], {`FE_BLK_SHIFT{1'b0}}};
  endfunction

  hist_t      hist;
  logic [1:0] take;
  logic       any_take;
  slot_t      sel;
  br_kind_e   sel_kind;
  ip_t        seq_next;
  ip_t        pred_next;
  ip_t        fix_ip;
  logic       redirect;

  assign lookup.ip   = fetch_ip;
  assign lookup.hist = hist;

  // conditional slots need a taken prediction, everything else always jumps
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      take[s] = lookup.hit[s] && (lookup.kind[s] != br_cond || lookup.taken_pred[s]);
    end
  end

  assign any_take = |take;
  assign sel      = take[0] ? 1'b0 : 1'b1;   // lowest slot wins
  assign sel_kind = lookup.kind[sel];
  assign seq_next = fetch_ip + BLK_BYTES;

  always_comb begin
    if (!any_take)
      pred_next = seq_next;
    else if (sel_kind == br_ret)
      pred_next = ras_top;
    else
      pred_next = blk_align(lookup.target[sel]);
  end

  // retire side
  assign redirect = retire_valid && retire_mispredict;
  assign fix_ip   = retire_taken ? blk_align(retire_target)
                                 : blk_align(retire_src_ip) + BLK_BYTES;

  assign update.wr     = redirect;
  assign update.slot   = retire_slot;
  assign update.kind   = retire_kind;
  assign update.src_ip = retire_src_ip;
  assign update.target = retire_target;
  assign update.ghist  = retire_ghist;

  // stack moves only when the prediction is actually used
  assign ras_push      = !fetch_stall && !redirect && any_take && sel_kind == br_call;
  assign ras_pop       = !fetch_stall && !redirect && any_take && sel_kind == br_ret;
  assign ras_push_addr = seq_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip <= `FE_RESET_IP;
      hist     <= '0;
    end else if (redirect) begin
      fetch_ip <= fix_ip;
      hist     <= {retire_ghist[`FE_HIST_W-2:0], retire_taken};
    end else if (!fetch_stall) begin
      fetch_ip <= pred_next;
      if (|lookup.hit) hist <= {hist[`FE_HIST_W-2:0], any_take};  // one bit per hit block
    end
  end

  assign fetch_valid = !rst && !fetch_stall;

endmodule

/* logic/fe_target_buf.sv */
// two-slot set-indexed branch target buffer
// lookup is combinational, install on a retire mispredict
// only the valid bits are cleared by reset
`include "fe_cfg.svh"

module fe_target_buf
  import fe_addr_pkg::*, fe_branch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  fe_lookup_if.tbuf lookup,
  fe_update_if.tbuf update
);

  localparam int SETS = 1 << `FE_TB_IDX_W;

  tb_entry_t ent [SETS][2];

  tb_idx_t rd_set;
  tb_tag_t rd_tag;
  tb_idx_t wr_set;
  tb_tag_t wr_tag;

  assign rd_set = lookup.ip[`FE_BLK_SHIFT +: `FE_TB_IDX_W];
  assign rd_tag = lookup.ip[`FE_IP_W-1 -: `FE_TB_TAG_W];
  assign wr_set = update.src_ip[`FE_BLK_SHIFT +: `FE_TB_IDX_W];
  assign wr_tag = update.src_ip[`FE_IP_W-1 -: `FE_TB_TAG_W];

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      lookup.hit[s]    = ent[rd_set][s].valid && ent[rd_set][s].tag == rd_tag;
      lookup.kind[s]   = ent[rd_set][s].kind;
      lookup.target[s] = ent[rd_set][s].target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SETS; i++) begin
        ent[i][0].valid <= 1'b0;
        ent[i][1].valid <= 1'b0;
      end
    end else if (update.wr) begin
      // replaces whatever the slot held
      ent[wr_set][update.slot] <= '{valid:  1'b1,
                                    tag:    wr_tag,
                                    target: update.target,
                                    kind:   update.kind};
    end
  end

endmodule

/* logic/fe_dir_pred.sv */
// three direction tables, prediction is the XOR of their bits
// training toggles the retiring slot's bit in every table, br_cond only
// index hashing uses fixed address and history bit ranges
`include "fe_cfg.svh"

module fe_dir_pred
  import fe_addr_pkg::*, fe_branch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  fe_lookup_if.pred lookup,
  fe_update_if.pred update
);

  localparam int TAB_N = 1 << `FE_PRED_IDX_W;

  // long address / short history down to short address / long history
  function automatic pred_idx_t tab_idx(input int unsigned t, input ip_t ip, input hist_t h);
    case (t)
      0:       return {ip[11:4], h[1:0]};
      1:       return {ip[7:4], h[5:0]};
      default: return {ip[5:4], h[7:0]};
    endcase
  endfunction

  logic [1:0] rd_bits [3];
  logic       train;

  assign train = update.wr && update.kind == br_cond;

  for (genvar t = 0; t < 3; t++) begin : g_tab
    logic [1:0] tab [TAB_N];   // bit per slot
    pred_idx_t  ridx;
    pred_idx_t  widx;

    assign ridx       = tab_idx(t, lookup.ip, lookup.hist);
    assign widx       = tab_idx(t, update.src_ip, update.ghist);
    assign rd_bits[t] = tab[ridx];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < TAB_N; i++) begin
          tab[i] <= '0;
        end
      end else if (train) begin
        tab[widx][update.slot] <= ~tab[widx][update.slot];
      end
    end
  end

  assign lookup.taken_pred = rd_bits[0] ^ rd_bits[1] ^ rd_bits[2];

endmodule

/* logic/fe_return_stack.sv */
// circular return-address stack, overflow overwrites the oldest entry
// pop of an empty stack gives the last slot, contents are not reset
`include "fe_cfg.svh"

module fe_return_stack
  import fe_addr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic pop,
  input  ip_t  push_addr,
  output ip_t  top
);

  localparam int PTR_W = $clog2(`FE_RAS_DEPTH);

  ip_t              stk [`FE_RAS_DEPTH];
  logic [PTR_W-1:0] ptr;      // points at current top
  logic [PTR_W-1:0] wr_ptr;

  assign wr_ptr = ptr + 1'b1;
  assign top    = stk[ptr];

  always_ff @(posedge clk) begin
    if (rst)
      ptr <= PTR_W'(`FE_RAS_DEPTH - 1);   // first push lands in slot 0
    else if (push)
      ptr <= wr_ptr;
    else if (pop)
      ptr <= ptr - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (push) stk[wr_ptr] <= push_addr;
  end

endmodule

/* logic/fe_top.sv */
// branch-prediction front end, one 16-byte fetch block per cycle
// retire inputs are sampled only when retire_valid and retire_mispredict are both high
// fetch addresses are block aligned
module fe_top
  import fe_addr_pkg::*, fe_branch_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     fetch_stall,
  input  logic     retire_valid,
  input  logic     retire_mispredict,
  input  slot_t    retire_slot,
  input  br_kind_e retire_kind,
  input  logic     retire_taken,
  input  ip_t      retire_src_ip,
  input  ip_t      retire_target,
  input  hist_t    retire_ghist,
  output ip_t      fetch_ip,
  output logic     fetch_valid
);

  fe_lookup_if lookup ();
  fe_update_if update ();

  logic ras_push;
  logic ras_pop;
  ip_t  ras_push_addr;
  ip_t  ras_top;

  fe_fetch_seq i_fe_fetch_seq (
    .clk               (clk),
    .rst               (rst),
    .fetch_stall       (fetch_stall),
    .retire_valid      (retire_valid),
    .retire_mispredict (retire_mispredict),
    .retire_slot       (retire_slot),
    .retire_kind       (retire_kind),
    .retire_taken      (retire_taken),
    .retire_src_ip     (retire_src_ip),
    .retire_target     (retire_target),
    .retire_ghist      (retire_ghist),
    .lookup            (lookup.seq),
    .update            (update.seq),
    .ras_top           (ras_top),
    .ras_push          (ras_push),
    .ras_pop           (ras_pop),
    .ras_push_addr     (ras_push_addr),
    .fetch_ip          (fetch_ip),
    .fetch_valid       (fetch_valid)
  );

  fe_target_buf i_fe_target_buf (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup.tbuf),
    .update (update.tbuf)
  );

  fe_dir_pred i_fe_dir_pred (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup.pred),
    .update (update.pred)
  );

  fe_return_stack i_fe_return_stack (
    .clk       (clk),
    .rst       (rst),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr),
    .top       (ras_top)
  );

endmodule

/* dv/fe_clk_gen.sv */
// testbench clock and synchronous reset
// reset drops after RST_CYCLES rising edges
module fe_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* dv/fe_checker.sv */
// fetch sequencing assertions, bound into fe_top
// fail_cnt is read by the testbench at the end of the run
`include "fe_cfg.svh"

module fe_checker
  import fe_addr_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic fetch_stall,
  input logic retire_valid,
  input logic retire_mispredict,
  input ip_t  fetch_ip,
  input logic fetch_valid
);

  int fail_cnt = 0;

  a_reset_invalid: assert property (@(posedge clk) rst |-> !fetch_valid)
    else begin
      fail_cnt++;
      $error("fetch_valid high during reset");
    end

  // a retire redirect still moves fetch under stall
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_stall && !(retire_valid && retire_mispredict) |=> $stable(fetch_ip))
    else begin
      fail_cnt++;
      $error("fetch_ip moved under stall");
    end

  a_block_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_ip[`FE_BLK_SHIFT-1:0] == '0)
    else begin
      fail_cnt++;
      $error("fetch_ip not block aligned");
    end

endmodule

/* dv/fe_tb.sv */
// directed tests for the fetch front end, one step per clock
// a cycle model of buffer, tables, history and return stack predicts fetch_ip
// each test keeps its addresses in its own 64 KiB region and never pops an empty stack
`include "fe_cfg.svh"

module fe_tb
  import fe_addr_pkg::*, fe_branch_pkg::*;
();

  localparam int  PERIOD      = 20;
  localparam int  RST_CYCLES  = 8;
  localparam int  TEST_CYCLES = 70;   // all tests together
  localparam int  MARGIN      = 100;
  localparam int  SETS        = 1 << `FE_TB_IDX_W;
  localparam int  PTR_W       = $clog2(`FE_RAS_DEPTH);
  localparam ip_t BLK         = ip_t'(1 << `FE_BLK_SHIFT);
  localparam ip_t FAR_IP      = 32'h00f0_03f0;   // source block of helper jumps, set 63

  logic     clk, rst, fetch_stall, fetch_valid;
  logic     retire_valid, retire_mispredict, retire_taken;
  slot_t    retire_slot;
  br_kind_e retire_kind;
  ip_t      retire_src_ip, retire_target, fetch_ip;
  hist_t    retire_ghist;
  int       n_mismatch, n_other;

  // model state
  tb_entry_t        m_btb [SETS][2];
  logic [1:0]       m_tab [3][1 << `FE_PRED_IDX_W];
  ip_t              m_stk [`FE_RAS_DEPTH];
  logic [PTR_W-1:0] m_ptr;
  hist_t            m_hist;
  ip_t              m_ip;

  fe_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) i_fe_clk_gen (.clk(clk), .rst(rst));

  fe_top i_fe_top (.*);

  bind fe_top fe_checker i_fe_checker (.*);

  function automatic ip_t align(input ip_t a);
    return a & ~(BLK - 1);
  endfunction

  // table A: addr 11:4 + hist 1:0, B: addr 7:4 + hist 5:0, C: addr 5:4 + hist 7:0
  function automatic pred_idx_t hash_index(input int t, input ip_t a, input hist_t h);
    case (t)
      0:       return {a[11:4], h[1:0]};
      1:       return {a[7:4], h[5:0]};
      default: return {a[5:4], h[7:0]};
    endcase
  endfunction

  task automatic check_ip(input ip_t got, input ip_t exp, input string what);
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("mismatch at %0t: fetch_valid got %b expected %b", $time, got, exp);
    end
  endtask

  // drive stall, advance the model one clock, compare at the next falling edge
  task automatic step(input logic stall);
    tb_entry_t  e;
    tb_idx_t    set;
    logic [1:0] hit, take;
    logic       pbit;
    ip_t        nxt;
    fetch_stall = stall;
    nxt         = m_ip;
    if (retire_valid && retire_mispredict) begin
      nxt = retire_taken ? align(retire_target) : align(retire_src_ip) + BLK;
      set = retire_src_ip[`FE_BLK_SHIFT +: `FE_TB_IDX_W];
      m_btb[set][retire_slot] = '{1'b1, retire_src_ip[`FE_IP_W-1 -: `FE_TB_TAG_W],
                                 retire_target, retire_kind};
      if (retire_kind == br_cond) begin
        for (int t = 0; t < 3; t++) begin
          m_tab[t][hash_index(t, retire_src_ip, retire_ghist)][retire_slot] ^= 1'b1;
        end
      end
      m_hist = {retire_ghist[`FE_HIST_W-2:0], retire_taken};
    end else if (!stall) begin
      set = m_ip[`FE_BLK_SHIFT +: `FE_TB_IDX_W];
      for (int s = 0; s < 2; s++) begin
        e    = m_btb[set][s];
        pbit = 1'b0;
        for (int t = 0; t < 3; t++) begin
          pbit ^= m_tab[t][hash_index(t, m_ip, m_hist)][s];
        end
        hit[s]  = e.valid && e.tag == m_ip[`FE_IP_W-1 -: `FE_TB_TAG_W];
        take[s] = hit[s] && (e.kind != br_cond || pbit);
      end
      e   = m_btb[set][take[0] ? 0 : 1];
      nxt = m_ip + BLK;
      if (|take && e.kind == br_ret) begin
        nxt = m_stk[m_ptr];
        m_ptr--;
      end else if (|take) begin
        nxt = align(e.target);
        if (e.kind == br_call) begin
          m_ptr++;
          m_stk[m_ptr] = m_ip + BLK;
        end
      end
      if (|hit) m_hist = {m_hist[`FE_HIST_W-2:0], |take};
    end
    m_ip = nxt;
    @(posedge clk);
    @(negedge clk);
    check_ip(fetch_ip, m_ip, "fetch_ip");
    check_valid(fetch_valid, !stall);
  endtask

  task automatic retire(input br_kind_e kind, input slot_t slot, input logic taken,
                        input ip_t src, input ip_t tgt, input hist_t gh, input logic mp);
    retire_valid      = 1'b1;
    retire_mispredict = mp;
    retire_kind       = kind;
    retire_slot       = slot;
    retire_taken      = taken;
    retire_src_ip     = src;
    retire_target     = tgt;
    retire_ghist      = gh;
    step(1'b0);
    retire_valid      = 1'b0;
    retire_mispredict = 1'b0;
  endtask

  // land on dst with history {gh, 1}
  task automatic jump_to(input ip_t dst, input hist_t gh);
    retire(br_uncond, 1'b0, 1'b1, FAR_IP, dst, gh, 1'b1);
  endtask

  task automatic test_reset_stream();
    check_ip(fetch_ip, `FE_RESET_IP, "fetch_ip after reset");
    repeat (5) step(1'b0);
    repeat (3) step(1'b1);
    repeat (2) step(1'b0);
  endtask

  task automatic test_uncond_redirect();
    ip_t src, tgt;
    src = 32'h0002_0000 | ($urandom & 32'h1f0);
    tgt = 32'h0012_0000 | ($urandom & 32'h3f0);
    retire(br_uncond, 1'b0, 1'b1, src, tgt, m_hist, 1'b1);
    check_ip(fetch_ip, tgt, "redirect target");
    repeat (3) step(1'b0);
    jump_to(src, '0);
    step(1'b0);
    check_ip(fetch_ip, tgt, "buffered jump");
    repeat (2) step(1'b0);
  endtask

  task automatic test_cond_training();
    ip_t   src, tgt, pre;
    hist_t ga, h;
    src = 32'h0003_0000 | ($urandom & 32'h1f0);
    tgt = 32'h0013_0000 | ($urandom & 32'h3f0);
    pre = src | 32'h400;                  // same set as src, slot 1
    ga  = hist_t'($urandom);
    h   = {ga[`FE_HIST_W-3:0], 2'b11};    // at src after jump_to(pre) and the jump at pre
    retire(br_uncond, 1'b1, 1'b1, pre, src, '0, 1'b1);
    retire(br_cond, 1'b0, 1'b1, src, tgt, h, 1'b1);
    repeat (2) step(1'b0);
    jump_to(pre, ga);
    repeat (2) step(1'b0);
    check_ip(fetch_ip, tgt, "cond predicted taken");
    repeat (2) step(1'b0);
    // src + 16 trained for history {h, 0}
    retire(br_cond, 1'b0, 1'b1, src + BLK, tgt, {h[`FE_HIST_W-2:0], 1'b0}, 1'b1);
    retire(br_cond, 1'b0, 1'b0, src, tgt, h, 1'b1);
    step(1'b0);
    check_ip(fetch_ip, tgt, "not-taken retire in history");
    jump_to(pre, ga);
    repeat (2) step(1'b0);
    check_ip(fetch_ip, src + BLK, "cond predicted not taken");
    step(1'b0);
    check_ip(fetch_ip, tgt, "not-taken prediction in history");
    repeat (2) step(1'b0);
  endtask

  task automatic test_call_return();
    ip_t c1, f1, f2;
    c1 = 32'h0004_0000 | ($urandom & 32'h0f0);
    f1 = c1 + 32'h100;
    f2 = c1 + 32'h200;
    retire(br_call, 1'b0, 1'b1, c1, f1, '0, 1'b1);
    retire(br_call, 1'b0, 1'b1, f1, f2, '0, 1'b1);
    retire(br_ret, 1'b0, 1'b1, f2, f1 + BLK, '0, 1'b1);
    retire(br_ret, 1'b0, 1'b1, f1 + BLK, c1 + BLK, '0, 1'b1);
    step(1'b0);
    jump_to(c1, '0);
    repeat (4) step(1'b0);   // call, call, return, return
    check_ip(fetch_ip, c1 + BLK, "nested return");
    repeat (2) step(1'b0);
  endtask

  task automatic test_not_taken_priority();
    ip_t   s, t0, t1;
    hist_t ga;
    s  = 32'h0005_0000 | ($urandom & 32'h0f0);
    t0 = 32'h0015_0000 | ($urandom & 32'h3f0);
    t1 = 32'h0025_0000 | ($urandom & 32'h3f0);
    ga = hist_t'($urandom);
    retire(br_uncond, 1'b1, 1'b1, s, t1, '0, 1'b1);
    retire(br_uncond, 1'b0, 1'b1, s, t0, '0, 1'b1);
    jump_to(s, '0);
    step(1'b0);
    check_ip(fetch_ip, t0, "slot 0 priority");
    retire(br_uncond, 1'b0, 1'b1, s, t1, '0, 1'b0);   // no mispredict, ignored
    retire(br_cond, 1'b1, 1'b0, s + 32'h200, t1, {ga[`FE_HIST_W-2:0], 1'b1}, 1'b1);
    check_ip(fetch_ip, s + 32'h210, "not taken redirect");
    step(1'b0);
    jump_to(s + 32'h200, ga);
    step(1'b0);
    check_ip(fetch_ip, t1, "trained slot 1");
    repeat (2) step(1'b0);
  endtask

  initial begin
    void'($urandom(32'h6a6d));
    fetch_stall       = 1'b0;
    retire_valid      = 1'b0;
    retire_mispredict = 1'b0;
    retire_taken      = 1'b0;
    retire_slot       = 1'b0;
    retire_kind       = br_cond;
    retire_src_ip     = '0;
    retire_target     = '0;
    retire_ghist      = '0;
    n_mismatch        = 0;
    n_other           = 0;
    for (int i = 0; i < SETS; i++) begin
      m_btb[i][0] = '0;
      m_btb[i][1] = '0;
    end
    for (int i = 0; i < (1 << `FE_PRED_IDX_W); i++) begin
      for (int t = 0; t < 3; t++) begin
        m_tab[t][i] = '0;
      end
    end
    m_ptr  = PTR_W'(`FE_RAS_DEPTH - 1);   // empty stack
    m_hist = '0;
    m_ip   = `FE_RESET_IP;
    @(negedge clk);
    check_valid(fetch_valid, 1'b0);
    while (rst) @(negedge clk);
    test_reset_stream();
    test_uncond_redirect();
    test_cond_training();
    test_call_return();
    test_not_taken_priority();
    n_other += i_fe_top.i_fe_checker.fail_cnt;
    $display("errors: %0d mismatches, %0d assertion failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #((RST_CYCLES + TEST_CYCLES + MARGIN) * PERIOD);
    $display("error: watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* fe_top.f */
+incdir+logic
logic/fe_addr_pkg.sv
logic/fe_branch_pkg.sv
logic/fe_if.sv
logic/fe_fetch_seq.sv
logic/fe_target_buf.sv
logic/fe_dir_pred.sv
logic/fe_return_stack.sv
logic/fe_top.sv
dv/fe_clk_gen.sv
dv/fe_checker.sv
dv/fe_tb.sv

/* Bender.yml */
package:
  name: fe_top

sources:
  - include_dirs:
      - logic
    files:
      - logic/fe_addr_pkg.sv
      - logic/fe_branch_pkg.sv
      - logic/fe_if.sv
      - logic/fe_fetch_seq.sv
      - logic/fe_target_buf.sv
      - logic/fe_dir_pred.sv
      - logic/fe_return_stack.sv
      - logic/fe_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/fe_clk_gen.sv
      - dv/fe_checker.sv
      - dv/fe_tb.sv
